//--- hw/phy_mgmt_pkg.sv
/*
 * PHY management register map
 * bus widths, lane and PLL counts, register addresses and bit fields
 */
package phy_mgmt_pkg;

	// bus word and address
	typedef logic [31:0] csr_word_t;
	typedef logic [7:0]  csr_addr_t;

	// transceiver size
	localparam int num_lanes = 4;
	localparam int num_plls  = 1;

	typedef logic [num_lanes-1:0] lane_vec_t;
	typedef logic [num_plls-1:0]  pll_vec_t;

	// interrupt registers
	localparam csr_addr_t addr_irq_mask         = 8'h10;
	localparam csr_addr_t addr_irq_pending      = 8'h11;
	// reset control
	localparam csr_addr_t addr_reset_ch_bitmask = 8'h41;
	localparam csr_addr_t addr_reset_control    = 8'h42;
	localparam csr_addr_t addr_reset_fine       = 8'h44;
	// PMA controls
	localparam csr_addr_t addr_loopback_serial  = 8'h61;
	localparam csr_addr_t addr_rx_set_locktoref = 8'h64;
	localparam csr_addr_t addr_rx_set_locktodata = 8'h65;
	// PMA status, read only
	localparam csr_addr_t addr_pll_locked       = 8'h62;
	localparam csr_addr_t addr_rx_lockedtoref   = 8'h66;
	localparam csr_addr_t addr_rx_lockedtodata  = 8'h67;
	localparam csr_addr_t addr_rx_signaldetect  = 8'h68;

	// any address outside the map
	localparam csr_word_t unmapped_word = '1;

	// reset_control, write side
	localparam int rc_tx_restart_bit = 0;
	localparam int rc_rx_restart_bit = 1;
	localparam int rc_reset_all_bit  = 2;
	// reset_control, read side
	localparam int rc_tx_ready_bit   = 0;
	localparam int rc_rx_ready_bit   = 1;

	// reset_fine, bit 0 is the unused PLL power-down slot
	typedef logic [3:0] reset_fine_t;
	localparam int rf_tx_digital_bit = 1;
	localparam int rf_rx_analog_bit  = 2;
	localparam int rf_rx_digital_bit = 3;

endpackage

//--- hw/phy_reset_pkg.sv
/*
 * reset sequencer and status definitions
 * sequencer states, timing counts and the synchronized status bundle
 */
package phy_reset_pkg;
	import phy_mgmt_pkg::*;

	// flops between raw transceiver status and the core
	localparam int sync_stages = 2;

	// sequencer timing in clk cycles
	localparam int pll_pd_cycles         = 16;
	localparam int rx_analog_cycles      = 16;
	localparam int digital_settle_cycles = 8;
	localparam int lock_timeout_cycles   = 1024;

	// one down-counter covers the longest wait
	localparam int seq_cnt_width = $clog2(lock_timeout_cycles + 1);
	typedef logic [seq_cnt_width-1:0] seq_cnt_t;

	typedef enum logic [2:0] {
		pll_pd,
		wait_pll_lock,
		tx_settle,
		rx_analog,
		wait_cdr_lock,
		rx_settle,
		ready
	} seq_state_t;

	// status after the synchronizer
	typedef struct packed {
		pll_vec_t  pll_locked;
		lane_vec_t rx_lockedtoref;
		lane_vec_t rx_lockedtodata;
		lane_vec_t rx_signaldetect;
	} xcvr_status_t;

endpackage

//--- hw/phy_mgmt_if.sv
/*
 * internal links of the PHY management block
 * register file to sequencer, register file to status synchronizer
 */

// restart requests down, sequencer resets and ready flags up
interface seq_if ();
	// one-cycle pulses from the register file
	logic restart_all;
	logic restart_tx;
	logic restart_rx;
	// sequencer results
	logic tx_ready;
	logic rx_ready;
	logic pll_powerdown;
	logic tx_digitalreset;
	logic rx_analogreset;
	logic rx_digitalreset;

	modport seq (
		input  restart_all, restart_tx, restart_rx,
		output tx_ready, rx_ready, pll_powerdown,
		output tx_digitalreset, rx_analogreset, rx_digitalreset
	);

	modport csr (
		output restart_all, restart_tx, restart_rx,
		input  tx_ready, rx_ready, pll_powerdown,
		input  tx_digitalreset, rx_analogreset, rx_digitalreset
	);
endinterface

// loss-of-lock interrupt mask, clear and pending
interface irq_if import phy_mgmt_pkg::*; ();
	lane_vec_t irq_mask;
	// write-one-to-clear pulses
	lane_vec_t irq_clear;
	lane_vec_t irq_pending;

	modport sync (input irq_mask, irq_clear, output irq_pending);
	modport csr (output irq_mask, irq_clear, input irq_pending);
endinterface

//--- hw/phy_status_sync.sv
/*
 * transceiver status synchronizer
 * brings raw lock status into clk and latches per-lane loss of lock
 */
module phy_status_sync import phy_mgmt_pkg::*, phy_reset_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  pll_vec_t     pll_locked,
	input  lane_vec_t    rx_is_lockedtoref,
	input  lane_vec_t    rx_is_lockedtodata,
	input  lane_vec_t    rx_signaldetect,
	input  logic         rx_ready,
	output xcvr_status_t status,
	output logic         irq,
	irq_if.sync          irq_bus
);

	xcvr_status_t raw;
	xcvr_status_t sync_q [sync_stages];
	lane_vec_t    lock_fall;

	// bundle the raw inputs
	always_comb begin
		raw.pll_locked      = pll_locked;
		raw.rx_lockedtoref  = rx_is_lockedtoref;
		raw.rx_lockedtodata = rx_is_lockedtodata;
		raw.rx_signaldetect = rx_signaldetect;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < sync_stages; i++)
				sync_q[i] <= '0;
		end else begin
			sync_q[0] <= raw;
			for (int i = 1; i < sync_stages; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	assign status = sync_q[sync_stages-1];

	// falling edge seen one stage early so pending lines up with status
	assign lock_fall = status.rx_lockedtodata & ~sync_q[sync_stages-2].rx_lockedtodata;

	// sticky per lane, clear wins over set
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			irq_bus.irq_pending <= '0;
		else
			irq_bus.irq_pending <= (irq_bus.irq_pending | (lock_fall & {num_lanes{rx_ready}}))
				& ~irq_bus.irq_clear;
	end

	assign irq = |(irq_bus.irq_pending & irq_bus.irq_mask);

endmodule

//--- hw/phy_reset_seq.sv
/*
 * automatic transceiver reset sequencer
 * powers up the PLL, then releases tx and rx resets in order
 */
module phy_reset_seq import phy_mgmt_pkg::*, phy_reset_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  xcvr_status_t status,
	seq_if.seq           seq_bus
);

	seq_state_t state;
	seq_state_t state_next;
	seq_cnt_t   cnt;
	seq_cnt_t   cnt_next;
	logic       plls_locked;
	logic       lanes_locked;

	// every PLL and every lane must agree
	assign plls_locked  = &status.pll_locked;
	assign lanes_locked = &status.rx_lockedtodata;

	always_comb begin
		state_next = state;
		// free-running count down, reloaded on each transition
		cnt_next = (cnt != '0) ? cnt - 1'b1 : cnt;
		case (state)
			pll_pd: begin
				if (cnt == '0) begin
					state_next = wait_pll_lock;
					cnt_next   = seq_cnt_t'(lock_timeout_cycles);
				end
			end
			wait_pll_lock: begin
				if (plls_locked) begin
					state_next = tx_settle;
					cnt_next   = seq_cnt_t'(digital_settle_cycles - 1);
				end else if (cnt == '0) begin
					// PLL never locked, start over
					state_next = pll_pd;
					cnt_next   = seq_cnt_t'(pll_pd_cycles - 1);
				end
			end
			tx_settle: begin
				if (cnt == '0) begin
					state_next = rx_analog;
					cnt_next   = seq_cnt_t'(rx_analog_cycles - 1);
				end
			end
			rx_analog: begin
				if (cnt == '0) begin
					state_next = wait_cdr_lock;
					cnt_next   = seq_cnt_t'(lock_timeout_cycles);
				end
			end
			wait_cdr_lock: begin
				if (lanes_locked) begin
					state_next = rx_settle;
					cnt_next   = seq_cnt_t'(digital_settle_cycles - 1);
				end else if (cnt == '0) begin
					state_next = pll_pd;
					cnt_next   = seq_cnt_t'(pll_pd_cycles - 1);
				end
			end
			rx_settle: begin
				if (cnt == '0)
					state_next = ready;
			end
			ready: begin
				// partial restarts only from a finished sequence
				if (seq_bus.restart_tx) begin
					state_next = tx_settle;
					cnt_next   = seq_cnt_t'(digital_settle_cycles - 1);
				end else if (seq_bus.restart_rx) begin
					state_next = rx_analog;
					cnt_next   = seq_cnt_t'(rx_analog_cycles - 1);
				end
			end
			default: begin
				state_next = pll_pd;
				cnt_next   = seq_cnt_t'(pll_pd_cycles - 1);
			end
		endcase
		// full restart overrides everything
		if (seq_bus.restart_all) begin
			state_next = pll_pd;
			cnt_next   = seq_cnt_t'(pll_pd_cycles - 1);
		end
	end

	// outputs registered from the next state, glitch free toward the PMA
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state                   <= pll_pd;
			cnt                     <= seq_cnt_t'(pll_pd_cycles - 1);
			seq_bus.pll_powerdown   <= 1'b1;
			seq_bus.tx_digitalreset <= 1'b1;
			seq_bus.rx_analogreset  <= 1'b1;
			seq_bus.rx_digitalreset <= 1'b1;
			seq_bus.tx_ready        <= 1'b0;
			seq_bus.rx_ready        <= 1'b0;
		end else begin
			state                   <= state_next;
			cnt                     <= cnt_next;
			seq_bus.pll_powerdown   <= (state_next == pll_pd);
			seq_bus.tx_digitalreset <= state_next inside {pll_pd, wait_pll_lock, tx_settle};
			seq_bus.rx_analogreset  <= state_next inside {pll_pd, wait_pll_lock, tx_settle,
				rx_analog};
			seq_bus.rx_digitalreset <= (state_next != ready);
			seq_bus.tx_ready        <= !(state_next inside {pll_pd, wait_pll_lock, tx_settle});
			seq_bus.rx_ready        <= (state_next == ready);
		end
	end

endmodule

//--- hw/phy_csr.sv
/*
 * PHY control and status register file
 * bus decode, restart and clear strobes, merging of automatic and manual resets
 */
module phy_csr import phy_mgmt_pkg::*, phy_reset_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  csr_addr_t    address,
	input  logic         read,
	input  logic         write,
	input  csr_word_t    writedata,
	input  xcvr_status_t status,
	output csr_word_t    readdata,
	output lane_vec_t    tx_digitalreset,
	output lane_vec_t    rx_analogreset,
	output lane_vec_t    rx_digitalreset,
	output logic         pll_powerdown,
	output lane_vec_t    loopback_serial,
	output lane_vec_t    rx_set_locktoref,
	output lane_vec_t    rx_set_locktodata,
	seq_if.csr           seq_bus,
	irq_if.csr           irq_bus
);

	lane_vec_t   reset_ch_bitmask;
	reset_fine_t reset_fine;
	csr_word_t   rd_word;
	logic        ctrl_wr;

	// write strobe for the reset control register
	assign ctrl_wr = write && (address == addr_reset_control);

	// read mux, status registers zero extended
	always_comb begin
		case (address)
			addr_irq_mask:          rd_word = csr_word_t'(irq_bus.irq_mask);
			addr_irq_pending:       rd_word = csr_word_t'(irq_bus.irq_pending);
			addr_reset_control: begin
				rd_word = '0;
				rd_word[rc_tx_ready_bit] = seq_bus.tx_ready;
				rd_word[rc_rx_ready_bit] = seq_bus.rx_ready;
			end
			addr_reset_ch_bitmask:  rd_word = csr_word_t'(reset_ch_bitmask);
			addr_reset_fine:        rd_word = csr_word_t'(reset_fine);
			addr_loopback_serial:   rd_word = csr_word_t'(loopback_serial);
			addr_rx_set_locktoref:  rd_word = csr_word_t'(rx_set_locktoref);
			addr_rx_set_locktodata: rd_word = csr_word_t'(rx_set_locktodata);
			addr_pll_locked:        rd_word = csr_word_t'(status.pll_locked);
			addr_rx_lockedtoref:    rd_word = csr_word_t'(status.rx_lockedtoref);
			addr_rx_lockedtodata:   rd_word = csr_word_t'(status.rx_lockedtodata);
			addr_rx_signaldetect:   rd_word = csr_word_t'(status.rx_signaldetect);
			default:                rd_word = unmapped_word;
		endcase
	end

	// one cycle read latency, held between reads
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			readdata <= '0;
		else if (read)
			readdata <= rd_word;
	end

	// writable registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			irq_bus.irq_mask  <= '1;
			reset_ch_bitmask  <= '1;
			reset_fine        <= '0;
			loopback_serial   <= '0;
			rx_set_locktoref  <= '0;
			rx_set_locktodata <= '0;
		end else if (write) begin
			case (address)
				addr_irq_mask:          irq_bus.irq_mask  <= writedata[num_lanes-1:0];
				addr_reset_ch_bitmask:  reset_ch_bitmask  <= writedata[num_lanes-1:0];
				addr_reset_fine:        reset_fine        <= writedata[$bits(reset_fine_t)-1:0];
				addr_loopback_serial:   loopback_serial   <= writedata[num_lanes-1:0];
				addr_rx_set_locktoref:  rx_set_locktoref  <= writedata[num_lanes-1:0];
				addr_rx_set_locktodata: rx_set_locktodata <= writedata[num_lanes-1:0];
				default: ;
			endcase
		end
	end

	// strobes, high only in the cycle after the write
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			seq_bus.restart_all <= 1'b0;
			seq_bus.restart_tx  <= 1'b0;
			seq_bus.restart_rx  <= 1'b0;
			irq_bus.irq_clear   <= '0;
		end else begin
			seq_bus.restart_all <= ctrl_wr && writedata[rc_reset_all_bit];
			seq_bus.restart_tx  <= ctrl_wr && writedata[rc_tx_restart_bit];
			seq_bus.restart_rx  <= ctrl_wr && writedata[rc_rx_restart_bit];
			// write one to clear pending
			if (write && (address == addr_irq_pending))
				irq_bus.irq_clear <= writedata[num_lanes-1:0];
			else
				irq_bus.irq_clear <= '0;
		end
	end

	// sequencer or manual reset, limited to the selected lanes
	assign tx_digitalreset = reset_ch_bitmask &
		{num_lanes{seq_bus.tx_digitalreset | reset_fine[rf_tx_digital_bit]}};
	assign rx_analogreset = reset_ch_bitmask &
		{num_lanes{seq_bus.rx_analogreset | reset_fine[rf_rx_analog_bit]}};
	assign rx_digitalreset = reset_ch_bitmask &
		{num_lanes{seq_bus.rx_digitalreset | reset_fine[rf_rx_digital_bit]}};

	// no manual path for PLL power-down
	assign pll_powerdown = seq_bus.pll_powerdown;

endmodule

//--- hw/phy_mgmt_top.sv
/*
 * PHY management top level
 * register file, reset sequencer and status synchronizer
 */
module phy_mgmt_top import phy_mgmt_pkg::*, phy_reset_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	// register bus
	input  csr_addr_t address,
	input  logic      read,
	input  logic      write,
	input  csr_word_t writedata,
	output csr_word_t readdata,
	// raw transceiver status
	input  pll_vec_t  pll_locked,
	input  lane_vec_t rx_is_lockedtoref,
	input  lane_vec_t rx_is_lockedtodata,
	input  lane_vec_t rx_signaldetect,
	// PMA and PCS controls
	output logic      pll_powerdown,
	output lane_vec_t tx_digitalreset,
	output lane_vec_t rx_analogreset,
	output lane_vec_t rx_digitalreset,
	output lane_vec_t loopback_serial,
	output lane_vec_t rx_set_locktoref,
	output lane_vec_t rx_set_locktodata,
	output logic      irq,
	output logic      tx_ready,
	output logic      rx_ready
);

	xcvr_status_t status;

	seq_if seq_bus ();
	irq_if irq_bus ();

	phy_status_sync sync_i (
		.clk, .reset,
		.pll_locked, .rx_is_lockedtoref, .rx_is_lockedtodata, .rx_signaldetect,
		.rx_ready (seq_bus.rx_ready),
		.status,
		.irq,
		.irq_bus  (irq_bus.sync)
	);

	phy_reset_seq seq_i (
		.clk, .reset,
		.status,
		.seq_bus (seq_bus.seq)
	);

	phy_csr csr_i (
		.clk, .reset,
		.address, .read, .write, .writedata, .readdata,
		.status,
		.tx_digitalreset, .rx_analogreset, .rx_digitalreset, .pll_powerdown,
		.loopback_serial, .rx_set_locktoref, .rx_set_locktodata,
		.seq_bus (seq_bus.csr),
		.irq_bus (irq_bus.csr)
	);

	// ready flags straight from the sequencer
	assign tx_ready = seq_bus.tx_ready;
	assign rx_ready = seq_bus.rx_ready;

endmodule

//--- verif/phy_mgmt_tb.sv
/*
 * testbench for the PHY management block
 * transceiver and register models, random bus and status stimulus
 */
module phy_mgmt_tb import phy_mgmt_pkg::*, phy_reset_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned seed = 32'h44aa_fee5;
	// well above one full power-up pass
	localparam int ready_timeout = 4 * lock_timeout_cycles;

	logic      clk = 1'b0;
	logic      reset = 1'b1;
	csr_addr_t address = '0;
	logic      read = 1'b0;
	logic      write = 1'b0;
	csr_word_t writedata = '0;
	csr_word_t readdata;
	pll_vec_t  pll_locked = '0;
	lane_vec_t rx_is_lockedtoref = '0;
	lane_vec_t rx_is_lockedtodata = '0;
	lane_vec_t rx_signaldetect = '0;
	logic      pll_powerdown;
	lane_vec_t tx_digitalreset;
	lane_vec_t rx_analogreset;
	lane_vec_t rx_digitalreset;
	lane_vec_t loopback_serial;
	lane_vec_t rx_set_locktoref;
	lane_vec_t rx_set_locktodata;
	logic      irq;
	logic      tx_ready;
	logic      rx_ready;

	// transceiver model controls
	logic      status_override = 1'b0;
	pll_vec_t  ovr_pll = '0;
	lane_vec_t ovr_ref = '0;
	lane_vec_t ovr_data = '0;
	lane_vec_t ovr_sd = '0;
	lane_vec_t lane_drop = '0;
	int        pll_wait = 0;
	int        lane_wait [num_lanes] = '{default: 0};

	// shadow of the writable registers from their reset values
	lane_vec_t   sh_irq_mask = '1;
	lane_vec_t   sh_ch_bitmask = '1;
	reset_fine_t sh_fine = '0;
	lane_vec_t   sh_loopback = '0;
	lane_vec_t   sh_locktoref = '0;
	lane_vec_t   sh_locktodata = '0;

	int   checks = 0;
	int   errors = 0;
	int   timeouts = 0;
	logic tx_hold = 1'b0;

	phy_mgmt_top dut_i (.*);

	always #4 clk = ~clk;

	// lock lands 5 to 40 cycles after the reset releases
	function automatic int lock_delay();
		return 4 + int'($urandom % 36);
	endfunction

	// transceiver model where each lock follows its own reset
	always @(posedge clk) begin
		if (status_override) begin
			pll_locked         <= ovr_pll;
			rx_is_lockedtoref  <= ovr_ref;
			rx_is_lockedtodata <= ovr_data;
			rx_signaldetect    <= ovr_sd;
		end else begin
			if (reset || pll_powerdown) begin
				pll_locked <= '0;
				pll_wait   <= lock_delay();
			end else if (pll_wait > 0) begin
				pll_wait <= pll_wait - 1;
			end else begin
				pll_locked <= '1;
			end
			for (int l = 0; l < num_lanes; l++) begin
				// CDR loses data lock in rx analog reset or a forced drop
				if (reset || rx_analogreset[l] || lane_drop[l]) begin
					rx_is_lockedtodata[l] <= 1'b0;
					lane_wait[l]          <= lock_delay();
				end else if (lane_wait[l] > 0) begin
					lane_wait[l] <= lane_wait[l] - 1;
				end else begin
					rx_is_lockedtodata[l] <= 1'b1;
				end
			end
			rx_is_lockedtoref <= ~rx_analogreset & {num_lanes{!reset}};
			rx_signaldetect   <= {num_lanes{!reset}};
		end
	end

	task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_lanes(input string name, input lane_vec_t got, input lane_vec_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	// rx restart must leave tx_ready up
	always @(negedge clk)
		if (tx_hold)
			check_bit("tx_ready", tx_ready, 1'b1);

	function automatic csr_word_t bit_word(input int pos);
		csr_word_t w;
		w = '0;
		w[pos] = 1'b1;
		return w;
	endfunction

	function automatic void update_shadow(input csr_addr_t addr, input csr_word_t data);
		case (addr)
			addr_irq_mask:          sh_irq_mask = lane_vec_t'(data);
			addr_reset_ch_bitmask:  sh_ch_bitmask = lane_vec_t'(data);
			addr_reset_fine:        sh_fine = reset_fine_t'(data);
			addr_loopback_serial:   sh_loopback = lane_vec_t'(data);
			addr_rx_set_locktoref:  sh_locktoref = lane_vec_t'(data);
			addr_rx_set_locktodata: sh_locktodata = lane_vec_t'(data);
			default: ;
		endcase
	endfunction

	// expected readback with narrow registers zero extended
	function automatic csr_word_t shadow_word(input csr_addr_t addr);
		case (addr)
			addr_irq_mask:          return csr_word_t'(sh_irq_mask);
			addr_reset_ch_bitmask:  return csr_word_t'(sh_ch_bitmask);
			addr_reset_fine:        return csr_word_t'(sh_fine);
			addr_loopback_serial:   return csr_word_t'(sh_loopback);
			addr_rx_set_locktoref:  return csr_word_t'(sh_locktoref);
			default:                return csr_word_t'(sh_locktodata);
		endcase
	endfunction

	function automatic logic is_mapped(input csr_addr_t addr);
		return addr inside {addr_irq_mask, addr_irq_pending, addr_reset_ch_bitmask,
			addr_reset_control, addr_reset_fine, addr_loopback_serial,
			addr_rx_set_locktoref, addr_rx_set_locktodata, addr_pll_locked,
			addr_rx_lockedtoref, addr_rx_lockedtodata, addr_rx_signaldetect};
	endfunction

	// write lands on the second edge
	task automatic bus_write(input csr_addr_t addr, input csr_word_t data);
		@(posedge clk);
		address   <= addr;
		writedata <= data;
		write     <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
		update_shadow(addr, data);
	endtask

	// readdata valid one cycle after the address is sampled
	task automatic expect_read(input csr_addr_t addr, input csr_word_t exp, input string name);
		@(posedge clk);
		address <= addr;
		read    <= 1'b1;
		@(posedge clk);
		read <= 1'b0;
		@(negedge clk);
		check_word({"readdata ", name}, readdata, exp);
	endtask

	task automatic report_timeout(input string what, input int cycles);
		timeouts++;
		$display("Timeout after %0d cycles waiting for %s", cycles, what);
	endtask

	task automatic wait_flags(input logic tx_want, input logic rx_want, input string what);
		int   cycles;
		logic ok;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < ready_timeout && timeouts == 0) begin
			@(negedge clk);
			cycles++;
			ok = (tx_ready === tx_want) && (rx_ready === rx_want);
		end
		if (!ok && timeouts == 0)
			report_timeout(what, cycles);
	endtask

	task automatic wait_lock(input lane_vec_t want, input string what);
		int   cycles;
		logic ok;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < ready_timeout && timeouts == 0) begin
			@(negedge clk);
			cycles++;
			ok = (rx_is_lockedtodata === want) && (&pll_locked === 1'b1);
		end
		if (!ok && timeouts == 0)
			report_timeout(what, cycles);
	endtask

	// relock every lane, then clear whatever loss of lock was latched
	task automatic settle_lanes();
		wait_lock('1, "all lanes to lock");
		repeat (sync_stages + 2) @(posedge clk);
		bus_write(addr_irq_pending, '1);
		expect_read(addr_irq_pending, '0, "irq_pending");
		check_bit("irq", irq, 1'b0);
	endtask

	task automatic power_up_test();
		// first cycle after reset is still in PLL power-down
		@(negedge clk);
		check_lanes("tx_digitalreset", tx_digitalreset, '1);
		check_lanes("rx_analogreset", rx_analogreset, '1);
		check_lanes("rx_digitalreset", rx_digitalreset, '1);
		check_bit("pll_powerdown", pll_powerdown, 1'b1);
		check_bit("tx_ready", tx_ready, 1'b0);
		check_bit("rx_ready", rx_ready, 1'b0);
		check_bit("irq", irq, 1'b0);
		check_lanes("loopback_serial", loopback_serial, '0);
		check_lanes("rx_set_locktoref", rx_set_locktoref, '0);
		check_lanes("rx_set_locktodata", rx_set_locktodata, '0);
		expect_read(addr_irq_mask, shadow_word(addr_irq_mask), "irq_mask");
		expect_read(addr_reset_ch_bitmask, shadow_word(addr_reset_ch_bitmask), "reset_ch_bitmask");
		wait_flags(1'b1, 1'b0, "tx_ready to rise");
		wait_flags(1'b1, 1'b1, "rx_ready to rise");
		check_lanes("tx_digitalreset", tx_digitalreset, '0);
		check_lanes("rx_analogreset", rx_analogreset, '0);
		check_lanes("rx_digitalreset", rx_digitalreset, '0);
		check_bit("pll_powerdown", pll_powerdown, 1'b0);
	endtask

	task automatic register_test();
		csr_addr_t addr;
		csr_addr_t bad;
		for (int i = 0; i < 24; i++) begin
			case ($urandom % 4)
				0: addr = addr_irq_mask;
				1: addr = addr_loopback_serial;
				2: addr = addr_rx_set_locktoref;
				default: addr = addr_rx_set_locktodata;
			endcase
			bus_write(addr, $urandom);
			@(negedge clk);
			check_lanes("loopback_serial", loopback_serial, sh_loopback);
			check_lanes("rx_set_locktoref", rx_set_locktoref, sh_locktoref);
			check_lanes("rx_set_locktodata", rx_set_locktodata, sh_locktodata);
			expect_read(addr, shadow_word(addr), "written register");
			// anything off the map reads all ones
			do
				bad = csr_addr_t'($urandom);
			while (is_mapped(bad));
			expect_read(bad, 32'hffff_ffff, "unmapped");
		end
	endtask

	task automatic reset_merge_test();
		for (int i = 0; i < 8; i++) begin
			bus_write(addr_reset_fine, $urandom);
			bus_write(addr_reset_ch_bitmask, $urandom);
			@(negedge clk);
			// sequencer resets are zero once ready
			check_lanes("tx_digitalreset", tx_digitalreset,
				sh_ch_bitmask & {num_lanes{sh_fine[rf_tx_digital_bit]}});
			check_lanes("rx_analogreset", rx_analogreset,
				sh_ch_bitmask & {num_lanes{sh_fine[rf_rx_analog_bit]}});
			check_lanes("rx_digitalreset", rx_digitalreset,
				sh_ch_bitmask & {num_lanes{sh_fine[rf_rx_digital_bit]}});
			check_bit("pll_powerdown", pll_powerdown, 1'b0);
			expect_read(addr_reset_fine, shadow_word(addr_reset_fine), "reset_fine");
			expect_read(addr_reset_ch_bitmask, shadow_word(addr_reset_ch_bitmask),
				"reset_ch_bitmask");
		end
		bus_write(addr_reset_fine, '0);
		bus_write(addr_reset_ch_bitmask, '1);
		settle_lanes();
	endtask

	task automatic status_test();
		for (int i = 0; i < 6; i++) begin
			@(posedge clk);
			ovr_pll         <= pll_vec_t'($urandom);
			ovr_ref         <= lane_vec_t'($urandom);
			ovr_data        <= lane_vec_t'($urandom);
			ovr_sd          <= lane_vec_t'($urandom);
			status_override <= 1'b1;
			// one edge for the model, then held for 4
			repeat (5) @(posedge clk);
			expect_read(addr_pll_locked, csr_word_t'(ovr_pll), "pll_locked");
			expect_read(addr_rx_lockedtoref, csr_word_t'(ovr_ref), "rx_lockedtoref");
			expect_read(addr_rx_lockedtodata, csr_word_t'(ovr_data), "rx_lockedtodata");
			expect_read(addr_rx_signaldetect, csr_word_t'(ovr_sd), "rx_signaldetect");
		end
		@(posedge clk);
		status_override <= 1'b0;
		settle_lanes();
	endtask

	task automatic restart_test();
		csr_word_t ready_word;
		ready_word = bit_word(rc_tx_ready_bit) | bit_word(rc_rx_ready_bit);
		expect_read(addr_reset_control, ready_word, "reset_control");
		// full restart drops both flags and brings them back in order
		bus_write(addr_reset_control, bit_word(rc_reset_all_bit));
		wait_flags(1'b0, 1'b0, "ready flags to drop after reset all");
		wait_flags(1'b1, 1'b0, "tx_ready to return after reset all");
		wait_flags(1'b1, 1'b1, "rx_ready to return after reset all");
		// tx restart passes through tx_settle
		bus_write(addr_reset_control, bit_word(rc_tx_restart_bit));
		wait_flags(1'b0, 1'b0, "ready flags to drop after tx restart");
		wait_flags(1'b1, 1'b1, "ready flags to return after tx restart");
		tx_hold = 1'b1;
		bus_write(addr_reset_control, bit_word(rc_rx_restart_bit));
		wait_flags(1'b1, 1'b0, "rx_ready to drop after rx restart");
		wait_flags(1'b1, 1'b1, "rx_ready to return after rx restart");
		tx_hold = 1'b0;
		expect_read(addr_reset_control, ready_word, "reset_control");
		settle_lanes();
	endtask

	task automatic irq_test();
		int        lane;
		lane_vec_t lane_bit;
		lane_vec_t mask;
		for (int i = 0; i < 6; i++) begin
			lane = int'($urandom % num_lanes);
			lane_bit = '0;
			lane_bit[lane] = 1'b1;
			// alternate masked and unmasked lanes
			mask = lane_vec_t'($urandom);
			mask[lane] = (i % 2 == 0);
			bus_write(addr_irq_mask, csr_word_t'(mask));
			@(posedge clk);
			lane_drop[lane] <= 1'b1;
			wait_lock(~lane_bit, "lane to lose data lock");
			repeat (sync_stages + 2) @(posedge clk);
			@(negedge clk);
			check_bit("irq", irq, mask[lane]);
			expect_read(addr_irq_pending, csr_word_t'(lane_bit), "irq_pending");
			@(posedge clk);
			lane_drop[lane] <= 1'b0;
			wait_lock('1, "lane to relock");
			bus_write(addr_irq_pending, csr_word_t'(lane_bit));
			expect_read(addr_irq_pending, '0, "irq_pending");
			check_bit("irq", irq, 1'b0);
		end
	endtask

	initial begin
		void'($urandom(seed));
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		power_up_test();
		if (timeouts == 0)
			register_test();
		if (timeouts == 0)
			reset_merge_test();
		if (timeouts == 0)
			status_test();
		if (timeouts == 0)
			restart_test();
		if (timeouts == 0)
			irq_test();
		repeat (4) @(posedge clk);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- compile.f
hw/phy_mgmt_pkg.sv
hw/phy_reset_pkg.sv
hw/phy_mgmt_if.sv
hw/phy_status_sync.sv
hw/phy_reset_seq.sv
hw/phy_csr.sv
hw/phy_mgmt_top.sv
verif/phy_mgmt_tb.sv

//--- Makefile
# Verilator build and run of the PHY management testbench

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module phy_mgmt_tb \
		-Mdir obj_dir -f compile.f
	./obj_dir/Vphy_mgmt_tb | tee sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
